// ==== source/id_pkg.sv ====
/*
 * shared decode definitions: opcode class enum, field widths,
 * RV32I major opcodes and the monitored-class helper
 */

package id_pkg;

    // ------------------------------------------------------------------------
    // widths
    // ------------------------------------------------------------------------
    // register index and data word
    localparam int unsigned REG_W = 5;
    localparam int unsigned XLEN  = 32;

    // ------------------------------------------------------------------------
    // major opcodes, bits [6:0] of a 32-bit instruction
    // ------------------------------------------------------------------------
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_IMM    = 7'b0010011;
    localparam logic [6:0] OPC_REG    = 7'b0110011;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    // decoded opcode class handed to issue
    typedef enum logic [3:0] {
        OP_LUI,
        OP_AUIPC,
        OP_JAL,
        OP_JALR,
        OP_BRANCH,
        OP_LOAD,
        OP_STORE,
        OP_IMM,
        OP_REG,
        OP_SYSTEM,
        OP_ILLEGAL
    } op_class_e;

    // memory and control-flow classes are watched by a runtime monitor
    function automatic logic is_monitored(input op_class_e op);
        return op inside {OP_JAL, OP_JALR, OP_BRANCH, OP_LOAD, OP_STORE};
    endfunction

endpackage

// ==== source/compressed_expander.sv ====
/*
 * RVC expander for c.addi, c.li, c.mv, c.add, c.lw, c.sw, c.j, c.beqz
 * and c.bnez; other 16-bit encodings are flagged illegal
 */

module compressed_expander (
    input  logic [31:0] instr_i,
    output logic [31:0] instr_o,
    output logic        is_compressed_o,
    output logic        illegal_o
);

    // any quadrant other than 2'b11 is a 16-bit instruction
    assign is_compressed_o = (instr_i[1:0] != 2'b11);

    always_comb begin
        // full-width words and unsupported forms pass through as is
        instr_o   = instr_i;
        illegal_o = 1'b0;

        if (is_compressed_o) begin
            // assume unsupported until a form below matches
            illegal_o = 1'b1;
            unique case ({instr_i[1:0], instr_i[15:13]})
                // ------------------------------------------------------------
                // quadrant 0, register fields are x8..x15
                // ------------------------------------------------------------
                // c.lw -> lw rd', uimm(rs1')
                5'b00_010: begin
                    instr_o   = {5'b0, instr_i[5], instr_i[12:10], instr_i[6], 2'b00,
                                 2'b01, instr_i[9:7], 3'b010, 2'b01, instr_i[4:2],
                                 id_pkg::OPC_LOAD};
                    illegal_o = 1'b0;
                end
                // c.sw -> sw rs2', uimm(rs1')
                5'b00_110: begin
                    instr_o   = {5'b0, instr_i[5], instr_i[12], 2'b01, instr_i[4:2],
                                 2'b01, instr_i[9:7], 3'b010, instr_i[11:10], instr_i[6],
                                 2'b00, id_pkg::OPC_STORE};
                    illegal_o = 1'b0;
                end
                // ------------------------------------------------------------
                // quadrant 1
                // ------------------------------------------------------------
                // c.addi -> addi rd, rd, simm6
                5'b01_000: begin
                    instr_o   = {{6{instr_i[12]}}, instr_i[12], instr_i[6:2], instr_i[11:7],
                                 3'b000, instr_i[11:7], id_pkg::OPC_IMM};
                    illegal_o = 1'b0;
                end
                // c.li -> addi rd, x0, simm6
                5'b01_010: begin
                    instr_o   = {{6{instr_i[12]}}, instr_i[12], instr_i[6:2], 5'b0,
                                 3'b000, instr_i[11:7], id_pkg::OPC_IMM};
                    illegal_o = 1'b0;
                end
                // c.j -> jal x0, offset
                // offset bits scattered as [11|4|9:8|10|6|7|3:1|5]
                5'b01_101: begin
                    instr_o   = {instr_i[12], instr_i[8], instr_i[10:9], instr_i[6],
                                 instr_i[7], instr_i[2], instr_i[11], instr_i[5:3],
                                 instr_i[12], {8{instr_i[12]}}, 5'b0, id_pkg::OPC_JAL};
                    illegal_o = 1'b0;
                end
                // c.beqz / c.bnez -> beq / bne rs1', x0, offset
                // funct3 bit 0 comes straight from instr[13]
                5'b01_110, 5'b01_111: begin
                    instr_o   = {{4{instr_i[12]}}, instr_i[6:5], instr_i[2], 5'b0,
                                 2'b01, instr_i[9:7], 2'b00, instr_i[13],
                                 instr_i[11:10], instr_i[4:3], instr_i[12],
                                 id_pkg::OPC_BRANCH};
                    illegal_o = 1'b0;
                end
                // ------------------------------------------------------------
                // quadrant 2, only c.mv and c.add
                // ------------------------------------------------------------
                5'b10_100: begin
                    // rs2 == 0 would be c.jr / c.jalr / c.ebreak, not supported
                    if (instr_i[6:2] != 5'b0) begin
                        // c.add adds rd to itself, c.mv uses x0
                        instr_o   = {7'b0, instr_i[6:2],
                                     instr_i[12] ? instr_i[11:7] : 5'b0,
                                     3'b000, instr_i[11:7], id_pkg::OPC_REG};
                        illegal_o = 1'b0;
                    end
                end
                default: begin
                    // everything else stays illegal
                    instr_o = instr_i;
                end
            endcase
        end
    end

endmodule

// ==== source/instr_decoder.sv ====
/*
 * RV32I decoder: opcode class, register indices and sign-extended
 * immediate of an expanded 32-bit instruction
 */

module instr_decoder (
    input  logic [31:0]                  instr_i,
    input  logic                         c_illegal_i,
    output id_pkg::op_class_e            op_o,
    output logic [id_pkg::REG_W-1:0]     rd_o,
    output logic [id_pkg::REG_W-1:0]     rs1_o,
    output logic [id_pkg::REG_W-1:0]     rs2_o,
    output logic [id_pkg::XLEN-1:0]      imm_o
);

    // ------------------------------------------------------------------------
    // immediate formats, all sign-extended from bit 31
    // ------------------------------------------------------------------------
    logic [id_pkg::XLEN-1:0] imm_i_type;
    logic [id_pkg::XLEN-1:0] imm_s_type;
    logic [id_pkg::XLEN-1:0] imm_b_type;
    logic [id_pkg::XLEN-1:0] imm_u_type;
    logic [id_pkg::XLEN-1:0] imm_j_type;

    assign imm_i_type = {{20{instr_i[31]}}, instr_i[31:20]};
    assign imm_s_type = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
    // branch and jump offsets are in half-words, bit 0 is always zero
    assign imm_b_type = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                         instr_i[11:8], 1'b0};
    assign imm_u_type = {instr_i[31:12], 12'b0};
    assign imm_j_type = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                         instr_i[30:21], 1'b0};

    // raw register fields
    logic [id_pkg::REG_W-1:0] rd_f;
    logic [id_pkg::REG_W-1:0] rs1_f;
    logic [id_pkg::REG_W-1:0] rs2_f;

    assign rd_f  = instr_i[11:7];
    assign rs1_f = instr_i[19:15];
    assign rs2_f = instr_i[24:20];

    // ------------------------------------------------------------------------
    // class decode
    // ------------------------------------------------------------------------
    always_comb begin
        // unused fields stay zero
        op_o  = id_pkg::OP_ILLEGAL;
        rd_o  = '0;
        rs1_o = '0;
        rs2_o = '0;
        imm_o = '0;

        // an illegal compressed form never reaches the opcode decode
        if (!c_illegal_i) begin
            unique case (instr_i[6:0])
                id_pkg::OPC_LUI: begin
                    op_o  = id_pkg::OP_LUI;
                    rd_o  = rd_f;
                    imm_o = imm_u_type;
                end
                id_pkg::OPC_AUIPC: begin
                    op_o  = id_pkg::OP_AUIPC;
                    rd_o  = rd_f;
                    imm_o = imm_u_type;
                end
                id_pkg::OPC_JAL: begin
                    op_o  = id_pkg::OP_JAL;
                    rd_o  = rd_f;
                    imm_o = imm_j_type;
                end
                id_pkg::OPC_JALR: begin
                    op_o  = id_pkg::OP_JALR;
                    rd_o  = rd_f;
                    rs1_o = rs1_f;
                    imm_o = imm_i_type;
                end
                // branches and stores write no register
                id_pkg::OPC_BRANCH: begin
                    op_o  = id_pkg::OP_BRANCH;
                    rs1_o = rs1_f;
                    rs2_o = rs2_f;
                    imm_o = imm_b_type;
                end
                id_pkg::OPC_STORE: begin
                    op_o  = id_pkg::OP_STORE;
                    rs1_o = rs1_f;
                    rs2_o = rs2_f;
                    imm_o = imm_s_type;
                end
                id_pkg::OPC_LOAD: begin
                    op_o  = id_pkg::OP_LOAD;
                    rd_o  = rd_f;
                    rs1_o = rs1_f;
                    imm_o = imm_i_type;
                end
                id_pkg::OPC_IMM: begin
                    op_o  = id_pkg::OP_IMM;
                    rd_o  = rd_f;
                    rs1_o = rs1_f;
                    imm_o = imm_i_type;
                end
                // register-register ops carry no immediate
                id_pkg::OPC_REG: begin
                    op_o  = id_pkg::OP_REG;
                    rd_o  = rd_f;
                    rs1_o = rs1_f;
                    rs2_o = rs2_f;
                end
                // csr number / funct12 rides in the I immediate
                id_pkg::OPC_SYSTEM: begin
                    op_o  = id_pkg::OP_SYSTEM;
                    rd_o  = rd_f;
                    rs1_o = rs1_f;
                    imm_o = imm_i_type;
                end
                default: begin
                    op_o = id_pkg::OP_ILLEGAL;
                end
            endcase
        end
    end

endmodule

// ==== source/monitor_lane_alloc.sv ====
/*
 * runtime-monitor lane allocator, lowest free lane first,
 * lanes held busy until the monitor releases them
 */

module monitor_lane_alloc #(
    parameter int unsigned NUM_LANES = 4
) (
    input  logic                                 clk_i,
    input  logic                                 rst_ni,
    input  id_pkg::op_class_e                    op_i,
    input  logic                                 accept_i,
    input  logic [NUM_LANES-1:0]                 lane_release_i,
    output logic                                 lane_grant_o,
    output logic [$clog2(NUM_LANES > 1 ? NUM_LANES : 2)-1:0] lane_id_o,
    output logic [NUM_LANES-1:0]                 lanes_busy_o
);

    localparam int unsigned LANE_W = $clog2(NUM_LANES > 1 ? NUM_LANES : 2);

    logic [NUM_LANES-1:0] busy_q;
    logic [NUM_LANES-1:0] busy_d;
    logic [NUM_LANES-1:0] grant_mask;
    logic [LANE_W-1:0]    free_id;
    logic                 free_found;

    // priority search, lowest index wins
    always_comb begin
        free_found = 1'b0;
        free_id    = '0;
        for (int i = 0; i < NUM_LANES; i++) begin
            if (!busy_q[i] && !free_found) begin
                free_found = 1'b1;
                free_id    = LANE_W'(i);
            end
        end
    end

    // no free lane just means no grant, the stage keeps going
    assign lane_grant_o = accept_i && id_pkg::is_monitored(op_i) && free_found;
    assign lane_id_o    = lane_grant_o ? free_id : '0;
    assign grant_mask   = lane_grant_o ? (NUM_LANES'(1) << free_id) : '0;

    // release first, then the grant sets its bit again
    assign busy_d = (busy_q & ~lane_release_i) | grant_mask;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            busy_q <= '0;
        end else begin
            busy_q <= busy_d;
        end
    end

    assign lanes_busy_o = busy_q;

endmodule

// ==== source/decode_stage.sv ====
/*
 * decode stage top: expander, decoder and lane allocator behind
 * the fetch valid/ready handshake, plus the issue register
 */

module decode_stage #(
    parameter int unsigned NUM_LANES = 4
) (
    input  logic                                 clk_i,
    input  logic                                 rst_ni,
    input  logic                                 flush_i,
    // fetch side
    input  logic [31:0]                          fetch_instr_i,
    input  logic [31:0]                          fetch_pc_i,
    input  logic                                 fetch_valid_i,
    output logic                                 fetch_ready_o,
    // issue side
    input  logic                                 issue_ack_i,
    output logic                                 issue_valid_o,
    output id_pkg::op_class_e                    issue_op_o,
    output logic [id_pkg::REG_W-1:0]             issue_rd_o,
    output logic [id_pkg::REG_W-1:0]             issue_rs1_o,
    output logic [id_pkg::REG_W-1:0]             issue_rs2_o,
    output logic [id_pkg::XLEN-1:0]              issue_imm_o,
    output logic [31:0]                          issue_pc_o,
    output logic                                 issue_compressed_o,
    output logic                                 issue_ctrl_flow_o,
    output logic                                 issue_lane_valid_o,
    output logic [$clog2(NUM_LANES > 1 ? NUM_LANES : 2)-1:0] issue_lane_id_o,
    // monitors
    input  logic [NUM_LANES-1:0]                 lane_release_i,
    output logic [NUM_LANES-1:0]                 lanes_busy_o
);

    localparam int unsigned LANE_W = $clog2(NUM_LANES > 1 ? NUM_LANES : 2);

    logic [31:0]              instr_exp;
    logic                     is_compressed;
    logic                     c_illegal;
    id_pkg::op_class_e        dec_op;
    logic [id_pkg::REG_W-1:0] dec_rd;
    logic [id_pkg::REG_W-1:0] dec_rs1;
    logic [id_pkg::REG_W-1:0] dec_rs2;
    logic [id_pkg::XLEN-1:0]  dec_imm;
    logic                     lane_grant;
    logic [LANE_W-1:0]        lane_id;
    logic                     accept;
    logic                     issue_valid_q;

    // ------------------------------------------------------------------------
    // expand, decode, allocate
    // ------------------------------------------------------------------------
    compressed_expander u_expander (
        .instr_i         (fetch_instr_i),
        .instr_o         (instr_exp),
        .is_compressed_o (is_compressed),
        .illegal_o       (c_illegal)
    );

    instr_decoder u_decoder (
        .instr_i     (instr_exp),
        .c_illegal_i (c_illegal),
        .op_o        (dec_op),
        .rd_o        (dec_rd),
        .rs1_o       (dec_rs1),
        .rs2_o       (dec_rs2),
        .imm_o       (dec_imm)
    );

    // room when empty, or when issue is draining the entry this cycle
    assign fetch_ready_o = !issue_valid_q || issue_ack_i;
    assign accept        = fetch_valid_i && fetch_ready_o;

    monitor_lane_alloc #(
        .NUM_LANES (NUM_LANES)
    ) u_lane_alloc (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .op_i           (dec_op),
        .accept_i       (accept),
        .lane_release_i (lane_release_i),
        .lane_grant_o   (lane_grant),
        .lane_id_o      (lane_id),
        .lanes_busy_o   (lanes_busy_o)
    );

    // ------------------------------------------------------------------------
    // issue register
    // ------------------------------------------------------------------------
    // flush beats a same-cycle accept, accept beats ack
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            issue_valid_q <= 1'b0;
        end else if (flush_i) begin
            issue_valid_q <= 1'b0;
        end else if (accept) begin
            issue_valid_q <= 1'b1;
        end else if (issue_ack_i) begin
            issue_valid_q <= 1'b0;
        end
    end

    // payload only loads on accept, held stable otherwise
    always_ff @(posedge clk_i) begin
        if (accept) begin
            issue_op_o         <= dec_op;
            issue_rd_o         <= dec_rd;
            issue_rs1_o        <= dec_rs1;
            issue_rs2_o        <= dec_rs2;
            issue_imm_o        <= dec_imm;
            issue_pc_o         <= fetch_pc_i;
            issue_compressed_o <= is_compressed;
            issue_lane_valid_o <= lane_grant;
            issue_lane_id_o    <= lane_id;
        end
    end

    assign issue_valid_o     = issue_valid_q;
    // jumps and branches redirect the pc
    assign issue_ctrl_flow_o = issue_op_o inside {id_pkg::OP_JAL, id_pkg::OP_JALR,
                                                  id_pkg::OP_BRANCH};

endmodule

// ==== dv/decode_tb_table.svh ====
/*
 * decode check table: instruction word and the fields expected on issue
 */
`ifndef DECODE_TB_TABLE_SVH
`define DECODE_TB_TABLE_SVH

// columns: instr, op, rd, rs1, rs2, imm, compressed
typedef struct packed {
    logic [31:0]       instr;
    id_pkg::op_class_e op;
    logic [4:0]        rd;
    logic [4:0]        rs1;
    logic [4:0]        rs2;
    logic [31:0]       imm;
    logic              compressed;
} decode_row_t;

localparam int NUM_ROWS = 22;

decode_row_t decode_rows [NUM_ROWS] = '{
    // RV32I: addi -5, lui, auipc, jal -8, jalr, beq -16, lw, sw -4, add, ecall
    '{32'hFFB10093, id_pkg::OP_IMM,     5'd1,  5'd2,  5'd0, 32'hFFFFFFFB, 1'b0},
    '{32'h123452B7, id_pkg::OP_LUI,     5'd5,  5'd0,  5'd0, 32'h12345000, 1'b0},
    '{32'hFFFFF197, id_pkg::OP_AUIPC,   5'd3,  5'd0,  5'd0, 32'hFFFFF000, 1'b0},
    '{32'hFF9FF0EF, id_pkg::OP_JAL,     5'd1,  5'd0,  5'd0, 32'hFFFFFFF8, 1'b0},
    '{32'h00408067, id_pkg::OP_JALR,    5'd0,  5'd1,  5'd0, 32'h00000004, 1'b0},
    '{32'hFE2088E3, id_pkg::OP_BRANCH,  5'd0,  5'd1,  5'd2, 32'hFFFFFFF0, 1'b0},
    '{32'h0085A503, id_pkg::OP_LOAD,    5'd10, 5'd11, 5'd0, 32'h00000008, 1'b0},
    '{32'hFEC6AE23, id_pkg::OP_STORE,   5'd0,  5'd13, 5'd12, 32'hFFFFFFFC, 1'b0},
    '{32'h005201B3, id_pkg::OP_REG,     5'd3,  5'd4,  5'd5, 32'h00000000, 1'b0},
    '{32'h00000073, id_pkg::OP_SYSTEM,  5'd0,  5'd0,  5'd0, 32'h00000000, 1'b0},
    // unknown major opcode 7'h7f
    '{32'h1234567F, id_pkg::OP_ILLEGAL, 5'd0,  5'd0,  5'd0, 32'h00000000, 1'b0},
    // compressed: c.addi x1 -5, c.li x5 7, c.mv x6 x7, c.add x6 x7
    '{32'h000010ED, id_pkg::OP_IMM,     5'd1,  5'd1,  5'd0, 32'hFFFFFFFB, 1'b1},
    '{32'h0000429D, id_pkg::OP_IMM,     5'd5,  5'd0,  5'd0, 32'h00000007, 1'b1},
    '{32'h0000831E, id_pkg::OP_REG,     5'd6,  5'd0,  5'd7, 32'h00000000, 1'b1},
    '{32'h0000931E, id_pkg::OP_REG,     5'd6,  5'd6,  5'd7, 32'h00000000, 1'b1},
    // c.lw x9 4(x10), c.sw x9 8(x10), c.j -8, c.beqz x8 -4, c.bnez x15 6
    '{32'h00004144, id_pkg::OP_LOAD,    5'd9,  5'd10, 5'd0, 32'h00000004, 1'b1},
    '{32'h0000C504, id_pkg::OP_STORE,   5'd0,  5'd10, 5'd9, 32'h00000008, 1'b1},
    '{32'h0000BFE5, id_pkg::OP_JAL,     5'd0,  5'd0,  5'd0, 32'hFFFFFFF8, 1'b1},
    '{32'h0000DC75, id_pkg::OP_BRANCH,  5'd0,  5'd8,  5'd0, 32'hFFFFFFFC, 1'b1},
    '{32'h0000E399, id_pkg::OP_BRANCH,  5'd0,  5'd15, 5'd0, 32'h00000006, 1'b1},
    // unsupported compressed: c.jr ra and the all-zero word
    '{32'h00008082, id_pkg::OP_ILLEGAL, 5'd0,  5'd0,  5'd0, 32'h00000000, 1'b1},
    '{32'h00000000, id_pkg::OP_ILLEGAL, 5'd0,  5'd0,  5'd0, 32'h00000000, 1'b1}
};

`endif

// ==== dv/decode_stage_tb.sv ====
/*
 * decode stage testbench with table-driven decode checks, back-pressure,
 * flush and monitor lane allocation against a lane model
 */

module decode_stage_tb;

    localparam int unsigned NUM_LANES = 4;
    localparam int unsigned LANE_W    = $clog2(NUM_LANES);
    localparam int          TIMEOUT   = 50;
    // op, three indices, imm and pc, three flags, lane id
    localparam int          SNAP_W    = 4 + 15 + 64 + 3 + LANE_W;

    logic                 clk = 1'b0;
    logic                 rst_n;
    logic                 flush;
    logic [31:0]          fetch_instr;
    logic [31:0]          fetch_pc;
    logic                 fetch_valid;
    logic                 fetch_ready;
    logic                 issue_ack;
    logic                 issue_valid;
    id_pkg::op_class_e    issue_op;
    logic [4:0]           issue_rd;
    logic [4:0]           issue_rs1;
    logic [4:0]           issue_rs2;
    logic [31:0]          issue_imm;
    logic [31:0]          issue_pc;
    logic                 issue_compressed;
    logic                 issue_ctrl_flow;
    logic                 issue_lane_valid;
    logic [LANE_W-1:0]    issue_lane_id;
    logic [NUM_LANES-1:0] lane_release;
    logic [NUM_LANES-1:0] lanes_busy;

    // lane model and the grant expected for the last accept
    logic [NUM_LANES-1:0] busy_model;
    logic                 exp_lane_valid;
    logic [LANE_W-1:0]    exp_lane_id;

    `include "decode_tb_table.svh"

    always #4 clk = ~clk;

    decode_stage #(
        .NUM_LANES (NUM_LANES)
    ) dut (
        .clk_i              (clk),
        .rst_ni             (rst_n),
        .flush_i            (flush),
        .fetch_instr_i      (fetch_instr),
        .fetch_pc_i         (fetch_pc),
        .fetch_valid_i      (fetch_valid),
        .fetch_ready_o      (fetch_ready),
        .issue_ack_i        (issue_ack),
        .issue_valid_o      (issue_valid),
        .issue_op_o         (issue_op),
        .issue_rd_o         (issue_rd),
        .issue_rs1_o        (issue_rs1),
        .issue_rs2_o        (issue_rs2),
        .issue_imm_o        (issue_imm),
        .issue_pc_o         (issue_pc),
        .issue_compressed_o (issue_compressed),
        .issue_ctrl_flow_o  (issue_ctrl_flow),
        .issue_lane_valid_o (issue_lane_valid),
        .issue_lane_id_o    (issue_lane_id),
        .lane_release_i     (lane_release),
        .lanes_busy_o       (lanes_busy)
    );

    // ------------------------------------------------------------------------
    // failure reporting and reference rules
    // ------------------------------------------------------------------------
    task automatic stop_on_failure();
        $display("test failed");
        $fatal(1);
    endtask

    task automatic value_error(input string msg);
        $display("** Error at time %0t: %s", $time, msg);
        stop_on_failure();
    endtask

    task automatic timeout_error(input string what);
        $display("gave up after %0d cycles waiting for %s", TIMEOUT, what);
        stop_on_failure();
    endtask

    task automatic check_field(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp)
        else value_error($sformatf("%s is %h, expected %h", name, got, exp));
    endtask

    // jumps and branches change the pc
    function automatic logic redirects(input id_pkg::op_class_e op);
        return op == id_pkg::OP_JAL || op == id_pkg::OP_JALR || op == id_pkg::OP_BRANCH;
    endfunction

    // memory and control-flow classes are watched by a monitor
    function automatic logic takes_lane(input id_pkg::op_class_e op);
        return redirects(op) || op == id_pkg::OP_LOAD || op == id_pkg::OP_STORE;
    endfunction

    function automatic logic [SNAP_W-1:0] issue_snapshot();
        return {issue_op, issue_rd, issue_rs1, issue_rs2, issue_imm, issue_pc,
                issue_compressed, issue_ctrl_flow, issue_lane_valid, issue_lane_id};
    endfunction

    // lowest free lane wins since releases never overlap an accept
    task automatic model_accept(input id_pkg::op_class_e op);
        exp_lane_valid = 1'b0;
        exp_lane_id    = '0;
        if (takes_lane(op)) begin
            for (int i = NUM_LANES - 1; i >= 0; i--) begin
                if (!busy_model[i]) begin
                    exp_lane_valid = 1'b1;
                    exp_lane_id    = LANE_W'(i);
                end
            end
        end
        if (exp_lane_valid) begin
            busy_model[exp_lane_id] = 1'b1;
        end
    endtask

    // ------------------------------------------------------------------------
    // handshake tasks sample outputs on the falling edge
    // ------------------------------------------------------------------------
    task automatic send_word(input logic [31:0] instr, input logic [31:0] pc,
                             input id_pkg::op_class_e op);
        int cycles = 0;
        @(posedge clk);
        fetch_valid <= 1'b1;
        fetch_instr <= instr;
        fetch_pc    <= pc;
        @(negedge clk);
        while (!fetch_ready) begin
            cycles++;
            if (cycles > TIMEOUT) begin
                timeout_error("fetch_ready_o");
            end
            @(negedge clk);
        end
        // accepted on this edge
        @(posedge clk);
        fetch_valid <= 1'b0;
        model_accept(op);
        @(negedge clk);
        assert (issue_valid) else value_error("no issue one cycle after accept");
        check_field("pc", issue_pc, pc);
        check_field("lane valid", 32'(issue_lane_valid), 32'(exp_lane_valid));
        if (exp_lane_valid) begin
            check_field("lane id", 32'(issue_lane_id), 32'(exp_lane_id));
        end
        check_field("lanes busy", 32'(lanes_busy), 32'(busy_model));
    endtask

    task automatic check_entry(input decode_row_t row, input logic [31:0] pc);
        check_field("op", 32'(issue_op), 32'(row.op));
        check_field("rd", 32'(issue_rd), 32'(row.rd));
        check_field("rs1", 32'(issue_rs1), 32'(row.rs1));
        check_field("rs2", 32'(issue_rs2), 32'(row.rs2));
        check_field("imm", issue_imm, row.imm);
        check_field("pc", issue_pc, pc);
        check_field("compressed", 32'(issue_compressed), 32'(row.compressed));
        check_field("ctrl flow", 32'(issue_ctrl_flow), 32'(redirects(row.op)));
    endtask

    task automatic wait_issue();
        int cycles = 0;
        @(negedge clk);
        while (!issue_valid) begin
            cycles++;
            if (cycles > TIMEOUT) begin
                timeout_error("issue_valid_o");
            end
            @(negedge clk);
        end
    endtask

    // hold the entry for some cycles and then acknowledge it for one cycle
    task automatic ack_entry(input int delay);
        logic [SNAP_W-1:0] held;
        held = issue_snapshot();
        repeat (delay) begin
            @(negedge clk);
            assert (!fetch_ready) else value_error("fetch_ready_o high under back-pressure");
            assert (issue_valid && issue_snapshot() === held)
            else value_error("issue entry changed before acknowledge");
        end
        @(posedge clk);
        issue_ack <= 1'b1;
        @(posedge clk);
        issue_ack <= 1'b0;
    endtask

    task automatic release_lanes(input logic [NUM_LANES-1:0] mask);
        @(posedge clk);
        lane_release <= mask;
        @(posedge clk);
        lane_release <= '0;
        busy_model = busy_model & ~mask;
        @(negedge clk);
        check_field("lanes busy", 32'(lanes_busy), 32'(busy_model));
    endtask

    // ------------------------------------------------------------------------
    // test sequence
    // ------------------------------------------------------------------------
    initial begin
        logic [31:0] pc;
        void'($urandom(32'h9353df7d));
        rst_n        <= 1'b0;
        flush        <= 1'b0;
        fetch_instr  <= '0;
        fetch_pc     <= '0;
        fetch_valid  <= 1'b0;
        issue_ack    <= 1'b0;
        lane_release <= '0;
        busy_model   = '0;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        assert (!issue_valid && fetch_ready && lanes_busy == '0)
        else value_error("stage not idle after reset");

        // decode table applied one entry at a time
        for (int i = 0; i < NUM_ROWS; i++) begin
            pc = 32'h0000_1000 + 32'(i * 4);
            send_word(decode_rows[i].instr, pc, decode_rows[i].op);
            check_entry(decode_rows[i], pc);
            ack_entry(0);
            @(negedge clk);
            assert (!issue_valid) else value_error("entry still valid after acknowledge");
            release_lanes(busy_model);
        end

        // back-pressure with random acknowledge delays keeps the order
        fork
            begin
                for (int k = 0; k < 4; k++) begin
                    send_word(decode_rows[k].instr, 32'h2000 + 32'(k * 4), decode_rows[k].op);
                end
            end
            begin
                for (int k = 0; k < 4; k++) begin
                    wait_issue();
                    check_entry(decode_rows[k], 32'h2000 + 32'(k * 4));
                    ack_entry(int'($urandom_range(5, 0)));
                end
            end
        join
        @(negedge clk);
        assert (!issue_valid) else value_error("extra entry issued under back-pressure");
        release_lanes(busy_model);

        // flush of a held entry
        send_word(decode_rows[0].instr, 32'h3000, decode_rows[0].op);
        @(posedge clk);
        flush <= 1'b1;
        @(posedge clk);
        flush <= 1'b0;
        @(negedge clk);
        assert (!issue_valid) else value_error("flush left issue_valid_o high");

        // flush in the accept cycle of a load leaves its lane busy
        @(posedge clk);
        fetch_valid <= 1'b1;
        fetch_instr <= decode_rows[6].instr;
        fetch_pc    <= 32'h3004;
        flush       <= 1'b1;
        @(negedge clk);
        assert (fetch_ready) else value_error("fetch_ready_o low on an empty stage");
        @(posedge clk);
        fetch_valid <= 1'b0;
        flush       <= 1'b0;
        model_accept(decode_rows[6].op);
        @(negedge clk);
        assert (!issue_valid) else value_error("flush did not drop the accepted word");
        check_field("lanes busy", 32'(lanes_busy), 32'(busy_model));
        send_word(decode_rows[8].instr, 32'h3008, decode_rows[8].op);
        check_entry(decode_rows[8], 32'h3008);
        ack_entry(int'($urandom_range(4, 0)));
        release_lanes(busy_model);

        // five loads fill four lanes and the fifth issues without one
        for (int k = 0; k < 5; k++) begin
            send_word(decode_rows[6].instr, 32'h4000 + 32'(k * 4), decode_rows[6].op);
            check_field("lane valid", 32'(issue_lane_valid), 32'(k < 4));
            if (k < 4) begin
                check_field("lane id", 32'(issue_lane_id), k);
            end
            ack_entry(0);
        end
        release_lanes(NUM_LANES'(2));
        // a non-monitored op leaves the freed lane for the next store
        send_word(decode_rows[0].instr, 32'h4020, decode_rows[0].op);
        assert (!issue_lane_valid) else value_error("non-monitored op got a lane");
        ack_entry(0);
        send_word(decode_rows[7].instr, 32'h4024, decode_rows[7].op);
        check_field("lane id", 32'(issue_lane_id), 1);
        ack_entry(0);
        release_lanes(busy_model);

        $display("test passed");
        $finish;
    end

endmodule

// ==== sim.f ====
+incdir+dv
source/id_pkg.sv
source/compressed_expander.sv
source/instr_decoder.sv
source/monitor_lane_alloc.sv
source/decode_stage.sv
dv/decode_stage_tb.sv

// ==== Makefile ====
# Verilator lint and simulation of the decode stage testbench

VERILATOR  ?= verilator
TOP        ?= decode_stage_tb
FILELIST   ?= sim.f
OBJ_DIR    ?= obj_dir
LINT_FLAGS ?= --lint-only --timing --assert
SIM_FLAGS  ?= --binary --timing --assert -j 0
PASS_MSG   := test passed

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# pass only if the run printed the pass line
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR) -o $(TOP)
	@out="$$(./$(OBJ_DIR)/$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
